/* all.f */
cpuPkg.sv
regFile.sv
fetchStage.sv
decodeStage.sv
executeStage.sv
writebackStage.sv
cpuTop.sv
cpuTb.sv

/* cpuTb.sv */
// Processor core testbench
`timescale 1ns/1ps
module cpuTb;
   import cpuPkg::*;

   localparam int rowCount = 12;
   localparam int progDepth = rowCount * 4;
   localparam int drainCycles = 60;
   localparam int timeoutCycles = rowCount * 200 + drainCycles;

   // One table row, expanded into in, in, op, out
   typedef struct packed {
      opcodeT op;
      wordT   a;
      wordT   b;
      immT    imm;
      regIdxT rx;
      regIdxT ry;
      regIdxT rz;
   } rowT;

   logic Clock = 1'b0;
   logic rstN = 1'b0;
   logic memReq;
   addrT memAddr;
   logic memAck = 1'b0;
   wordT memData = '0;
   logic inReq;
   logic inAck = 1'b0;
   wordT inData = '0;
   logic outReq;
   logic outAck = 1'b0;
   wordT outData;

   rowT rows [rowCount];
   wordT instrMem [progDepth];
   wordT inputVals [rowCount * 2];
   wordT expectedOut [rowCount];

   logic [15:0] lfsrState = 16'd30;
   int memWait = 0;
   int inWait = 0;
   int outWait = 0;
   int inIdx = 0;
   int outCount = 0;
   int cycleCount = 0;
   addrT nextFetch = '0;

   cpuTop i_dut (
      .Clock   (Clock),
      .rstN    (rstN),
      .memReq  (memReq),
      .memAddr (memAddr),
      .memAck  (memAck),
      .memData (memData),
      .inReq   (inReq),
      .inAck   (inAck),
      .inData  (inData),
      .outReq  (outReq),
      .outAck  (outAck),
      .outData (outData)
   );

   always #50 Clock = ~Clock;

   task automatic abortRun();
      $display("TB FAILED");
      $fatal(1);
   endtask

   task automatic compareWord(input string what, input wordT actual, input wordT expected);
      if (actual !== expected) begin
         $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
         abortRun();
      end
   endtask

   task automatic compareAddr(input string what, input addrT actual, input addrT expected);
      if (actual !== expected) begin
         $display("Mismatch at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
         abortRun();
      end
   endtask

   task automatic compareCount(input string what, input int actual, input int expected);
      if (actual != expected) begin
         $display("Mismatch at %0t ns: %s is %0d, expected %0d", $time, what, actual, expected);
         abortRun();
      end
   endtask

   // Galois LFSR, taps 16, 14, 13, 11
   function automatic logic [15:0] lfsrNext(input logic [15:0] s);
      return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
   endfunction

   // Three bits, one LFSR step each
   task automatic drawDelay(output int delay);
      delay = 0;
      for (int i = 0; i < 3; i++) begin
         lfsrState = lfsrNext(lfsrState);
         delay = (delay << 1) | lfsrState[0];
      end
   endtask

   function automatic logic isImmOp(input opcodeT op);
      return op == opAddi || op == opAndi || op == opOri;
   endfunction

   function automatic wordT encodeInstr(input opcodeT op, input regIdxT ra, input regIdxT rb,
                                        input regIdxT rc, input immT imm);
      wordT w;
      w = '0;
      w[opMsb:opLsb] = op;
      w[raMsb:raLsb] = ra;
      w[rbMsb:rbLsb] = rb;
      if (isImmOp(op)) begin
         w[immMsb:immLsb] = imm;
      end else begin
         w[rcMsb:rcLsb] = rc;
      end
      return w;
   endfunction

   // Value that the out of a row must show
   function automatic wordT expectedResult(input rowT r);
      wordT x;
      wordT y;
      wordT operandB;
      wordT res;
      // A second in to the same register overwrites the first
      x = (r.rx == 0) ? '0 : ((r.rx == r.ry) ? r.b : r.a);
      y = (r.ry == 0) ? '0 : r.b;
      if (isImmOp(r.op)) begin
         // Upper bits copy the immediate's sign
         operandB = '0;
         operandB[immWidth-1:0] = r.imm;
         if (r.imm[immWidth-1]) begin
            operandB[dataWidth-1:immWidth] = '1;
         end
      end else begin
         operandB = y;
      end
      case (r.op)
         opAdd, opAddi: res = x + operandB;
         opSub:         res = x - operandB;
         opAnd, opAndi: res = x & operandB;
         opOr, opOri:   res = x | operandB;
         opShl:         res = x << operandB[4:0];
         default:       res = '0;
      endcase
      return (r.rz == 0) ? '0 : res;
   endfunction

   task automatic setRow(input int idx, input opcodeT op, input wordT a, input wordT b,
                         input immT imm, input regIdxT rx, input regIdxT ry, input regIdxT rz);
      rows[idx].op = op;
      rows[idx].a = a;
      rows[idx].b = b;
      rows[idx].imm = imm;
      rows[idx].rx = rx;
      rows[idx].ry = ry;
      rows[idx].rz = rz;
   endtask

   task automatic buildTable();
      // Carry wrap, borrow wrap, dest reused as source
      setRow(0, opAdd, 32'hFFFF_FFFF, 32'h0000_0002, '0, 4'd1, 4'd2, 4'd3);
      setRow(1, opSub, 32'h0000_0005, 32'h0000_0007, '0, 4'd3, 4'd4, 4'd5);
      setRow(2, opAnd, 32'hF0F0_1234, 32'h0FF0_FF00, '0, 4'd5, 4'd6, 4'd5);
      setRow(3, opOr, 32'h1200_0000, 32'h0000_0034, '0, 4'd7, 4'd8, 4'd9);
      setRow(4, opShl, 32'h0000_0001, 32'h0000_001F, '0, 4'd9, 4'd10, 4'd11);
      // Shift amount with zero low bits
      setRow(5, opShl, 32'hDEAD_BEEF, 32'h0000_0020, '0, 4'd11, 4'd12, 4'd12);
      // Immediates of both signs
      setRow(6, opAddi, 32'h0000_0064, 32'h0000_0000, 19'h7FFFF, 4'd12, 4'd13, 4'd13);
      setRow(7, opAddi, 32'h0000_0010, 32'h0000_0000, 19'h00123, 4'd13, 4'd14, 4'd14);
      setRow(8, opOri, 32'h0000_0000, 32'h0000_0000, 19'h40000, 4'd14, 4'd15, 4'd1);
      setRow(9, opAndi, 32'h1234_5678, 32'h0000_0000, 19'h7FF0F, 4'd1, 4'd2, 4'd2);
      // Register zero as destination, then as source
      setRow(10, opAdd, 32'h0000_0003, 32'h0000_0004, '0, 4'd4, 4'd6, 4'd0);
      setRow(11, opAdd, 32'h0000_0009, 32'h0000_0006, '0, 4'd0, 4'd3, 4'd7);
   endtask

   task automatic loadProgram();
      for (int i = 0; i < rowCount; i++) begin
         instrMem[4*i] = encodeInstr(opIn, rows[i].rx, '0, '0, '0);
         instrMem[4*i+1] = encodeInstr(opIn, rows[i].ry, '0, '0, '0);
         instrMem[4*i+2] = encodeInstr(rows[i].op, rows[i].rz, rows[i].rx, rows[i].ry,
                                       rows[i].imm);
         instrMem[4*i+3] = encodeInstr(opOut, '0, rows[i].rz, '0, '0);
         inputVals[2*i] = rows[i].a;
         inputVals[2*i+1] = rows[i].b;
         expectedOut[i] = expectedResult(rows[i]);
      end
   endtask

   // Nop past the end of the program
   function automatic wordT fetchWord(input addrT addr);
      if (addr < progDepth) begin
         return instrMem[addr];
      end
      return encodeInstr(opNop, '0, '0, '0, '0);
   endfunction

   // Memory, input and output device models
   always @(posedge Clock) begin
      if (rstN) begin
         if (memReq && !memAck) begin
            if (memWait > 0) begin
               memWait--;
            end else begin
               // Each fetch asks for the next word in sequence
               compareAddr("fetch address", memAddr, nextFetch);
               nextFetch = nextFetch + 1'b1;
               memAck <= 1'b1;
               memData <= fetchWord(memAddr);
               drawDelay(memWait);
            end
         end else if (!memReq && memAck) begin
            memAck <= 1'b0;
         end

         if (inReq && !inAck) begin
            if (inWait > 0) begin
               inWait--;
            end else begin
               inAck <= 1'b1;
               inData <= (inIdx < rowCount * 2) ? inputVals[inIdx] : '0;
               inIdx++;
               drawDelay(inWait);
            end
         end else if (!inReq && inAck) begin
            inAck <= 1'b0;
         end

         if (outReq && !outAck) begin
            if (outWait > 0) begin
               outWait--;
            end else begin
               outAck <= 1'b1;
               if (outCount < rowCount) begin
                  compareWord($sformatf("out value of row %0d", outCount), outData,
                              expectedOut[outCount]);
               end
               outCount <= outCount + 1;
               drawDelay(outWait);
            end
         end else if (!outReq && outAck) begin
            outAck <= 1'b0;
         end
      end
   end

   always @(posedge Clock) begin
      cycleCount <= cycleCount + 1;
      if (cycleCount >= timeoutCycles) begin
         $display("Run did not finish within %0d cycles", timeoutCycles);
         abortRun();
      end
   end

   initial begin
      buildTable();
      loadProgram();
      repeat (2) @(posedge Clock);
      rstN <= 1'b1;
      wait (outCount == rowCount);
      // Extra window to catch a stray out
      repeat (drainCycles) @(posedge Clock);
      compareCount("out count", outCount, rowCount);
      $display("TB PASSED");
      $finish;
   end

endmodule

/* cpuTop.sv */
// Processor core top level
`timescale 1ns/1ps
module cpuTop (
   input  logic         Clock,
   input  logic         rstN,
   output logic         memReq,
   output cpuPkg::addrT memAddr,
   input  logic         memAck,
   input  cpuPkg::wordT memData,
   output logic         inReq,
   input  logic         inAck,
   input  cpuPkg::wordT inData,
   output logic         outReq,
   input  logic         outAck,
   output cpuPkg::wordT outData
);
   import cpuPkg::*;

   logic fetchReq;
   logic fetchAck;
   fetchT fetchBus;
   logic decReq;
   logic decAck;
   decodeT decBus;
   logic exReq;
   logic exAck;
   execT exBus;
   wbT wbBus;

   fetchStage i_fetch (
      .Clock    (Clock),
      .rstN     (rstN),
      .memReq   (memReq),
      .memAddr  (memAddr),
      .memAck   (memAck),
      .memData  (memData),
      .fetchReq (fetchReq),
      .fetchAck (fetchAck),
      .fetchOut (fetchBus)
   );

   decodeStage i_decode (
      .Clock    (Clock),
      .rstN     (rstN),
      .fetchReq (fetchReq),
      .fetchAck (fetchAck),
      .fetchIn  (fetchBus),
      .decReq   (decReq),
      .decAck   (decAck),
      .decOut   (decBus),
      .wbIn     (wbBus)
   );

   executeStage i_execute (
      .Clock  (Clock),
      .rstN   (rstN),
      .decReq (decReq),
      .decAck (decAck),
      .decIn  (decBus),
      .exReq  (exReq),
      .exAck  (exAck),
      .exOut  (exBus)
   );

   writebackStage i_writeback (
      .Clock   (Clock),
      .rstN    (rstN),
      .exReq   (exReq),
      .exAck   (exAck),
      .exIn    (exBus),
      .inReq   (inReq),
      .inAck   (inAck),
      .inData  (inData),
      .outReq  (outReq),
      .outAck  (outAck),
      .outData (outData),
      .wbOut   (wbBus)
   );

endmodule

/* writebackStage.sv */
// Writeback stage with device ports
`timescale 1ns/1ps
module writebackStage (
   input  logic         Clock,
   input  logic         rstN,
   input  logic         exReq,
   output logic         exAck,
   input  cpuPkg::execT exIn,
   output logic         inReq,
   input  logic         inAck,
   input  cpuPkg::wordT inData,
   output logic         outReq,
   input  logic         outAck,
   output cpuPkg::wordT outData,
   output cpuPkg::wbT   wbOut
);
   import cpuPkg::*;

   typedef enum logic [2:0] {
      stIdle,
      stRetire,
      stInWait,
      stInDrop,
      stOutWait,
      stOutDrop
   } wbStateT;

   wbStateT state;
   execT held;
   wordT inHeld;
   logic capture;

   assign capture = exReq && !exAck && state == stIdle;

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         state <= stIdle;
         exAck <= 1'b0;
         inReq <= 1'b0;
         outReq <= 1'b0;
         wbOut <= '0;
      end else begin
         // Write pulse lasts one cycle
         wbOut.writeEn <= 1'b0;

         if (capture) begin
            exAck <= 1'b1;
         end else if (!exReq && exAck) begin
            exAck <= 1'b0;
         end

         case (state)
            stIdle: begin
               if (capture) begin
                  case (exIn.op)
                     opIn: begin
                        inReq <= 1'b1;
                        state <= stInWait;
                     end
                     opOut: begin
                        outReq <= 1'b1;
                        state <= stOutWait;
                     end
                     default: state <= stRetire;
                  endcase
               end
            end
            stRetire: begin
               wbOut <= '{writeEn: held.writeEn, idx: held.dest, data: held.result};
               state <= stIdle;
            end
            stInWait: begin
               if (inAck) begin
                  inReq <= 1'b0;
                  state <= stInDrop;
               end
            end
            stInDrop: begin
               if (!inAck) begin
                  wbOut <= '{writeEn: held.writeEn, idx: held.dest, data: inHeld};
                  state <= stIdle;
               end
            end
            stOutWait: begin
               if (outAck) begin
                  outReq <= 1'b0;
                  state <= stOutDrop;
               end
            end
            stOutDrop: begin
               if (!outAck) begin
                  state <= stIdle;
               end
            end
            default: state <= stIdle;
         endcase
      end
   end

   always_ff @(posedge Clock) begin
      if (capture) begin
         held <= exIn;
      end
      if (capture && exIn.op == opOut) begin
         outData <= exIn.result;
      end
      // Device holds inData valid while inAck is high
      if (state == stInWait && inAck) begin
         inHeld <= inData;
      end
   end

   aOutDataStable: assert property (@(posedge Clock) disable iff (!rstN)
      outReq && $past(outReq) |-> $stable(outData));

endmodule

/* executeStage.sv */
// Execute stage with ALU
`timescale 1ns/1ps
module executeStage (
   input  logic           Clock,
   input  logic           rstN,
   input  logic           decReq,
   output logic           decAck,
   input  cpuPkg::decodeT decIn,
   output logic           exReq,
   input  logic           exAck,
   output cpuPkg::execT   exOut
);
   import cpuPkg::*;

   decodeT held;
   logic pending;
   logic capture;
   wordT result;

   assign capture = decReq && !decAck && !pending && !exReq && !exAck;

   always_comb begin
      case (held.op)
         opAdd, opAddi: result = held.opA + held.opB;
         opSub:         result = held.opA - held.opB;
         opAnd, opAndi: result = held.opA & held.opB;
         opOr, opOri:   result = held.opA | held.opB;
         opShl:         result = held.opA << held.opB[4:0];
         // Out passes A through to the port
         opOut:         result = held.opA;
         default:       result = '0;
      endcase
   end

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         decAck <= 1'b0;
         pending <= 1'b0;
         exReq <= 1'b0;
      end else begin
         if (capture) begin
            decAck <= 1'b1;
            pending <= 1'b1;
         end else if (!decReq && decAck) begin
            decAck <= 1'b0;
         end

         // One cycle from capture to req
         if (pending) begin
            exReq <= 1'b1;
            pending <= 1'b0;
         end else if (exReq && exAck) begin
            exReq <= 1'b0;
         end
      end
   end

   always_ff @(posedge Clock) begin
      if (capture) begin
         held <= decIn;
      end
      if (pending) begin
         exOut.op <= held.op;
         exOut.dest <= held.dest;
         exOut.result <= result;
         exOut.writeEn <= held.writeEn;
      end
   end

endmodule

/* decodeStage.sv */
// Instruction decode stage
`timescale 1ns/1ps
module decodeStage (
   input  logic           Clock,
   input  logic           rstN,
   input  logic           fetchReq,
   output logic           fetchAck,
   input  cpuPkg::fetchT  fetchIn,
   output logic           decReq,
   input  logic           decAck,
   output cpuPkg::decodeT decOut,
   input  cpuPkg::wbT     wbIn
);
   import cpuPkg::*;

   fetchT held;
   logic haveInstr;
   logic [regCount-1:0] busy;

   opcodeT op;
   regIdxT ra;
   regIdxT rb;
   regIdxT rc;
   immT imm;
   wordT immExt;
   wordT rbData;
   wordT rcData;
   logic isImm;
   logic useA;
   logic useB;
   logic writes;
   logic srcBusy;
   logic hazard;
   logic capture;
   logic issue;

   // Field split of the held instruction
   assign op = opcodeT'(held.instr[opMsb:opLsb]);
   assign ra = held.instr[raMsb:raLsb];
   assign rb = held.instr[rbMsb:rbLsb];
   assign rc = held.instr[rcMsb:rcLsb];
   assign imm = held.instr[immMsb:immLsb];
   assign immExt = {{(dataWidth - immWidth){imm[immWidth-1]}}, imm};

   always_comb begin
      isImm = op inside {opAddi, opAndi, opOri};
      useB = op inside {opAdd, opSub, opAnd, opOr, opShl};
      useA = !(op inside {opNop, opIn});
      writes = !(op inside {opNop, opOut});
   end

   assign srcBusy = (useA && busy[rb]) || (useB && busy[rc]);
   assign hazard = srcBusy || (writes && busy[ra]);
   assign capture = fetchReq && !fetchAck && !haveInstr && !decReq;
   assign issue = haveInstr && !decReq && !decAck && !hazard;

   regFile i_regFile (
      .Clock     (Clock),
      .rstN      (rstN),
      .readIdxA  (rb),
      .readIdxB  (rc),
      .readDataA (rbData),
      .readDataB (rcData),
      .writeEn   (wbIn.writeEn),
      .writeIdx  (wbIn.idx),
      .writeData (wbIn.data)
   );

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         fetchAck <= 1'b0;
         haveInstr <= 1'b0;
         decReq <= 1'b0;
         busy <= '0;
      end else begin
         if (capture) begin
            fetchAck <= 1'b1;
            haveInstr <= 1'b1;
         end else if (!fetchReq && fetchAck) begin
            fetchAck <= 1'b0;
         end

         if (issue) begin
            decReq <= 1'b1;
            haveInstr <= 1'b0;
         end else if (decReq && decAck) begin
            decReq <= 1'b0;
         end

         // Clear on write-back, set on issue
         if (wbIn.writeEn) begin
            busy[wbIn.idx] <= 1'b0;
         end
         if (issue && writes && ra != '0) begin
            busy[ra] <= 1'b1;
         end
      end
   end

   always_ff @(posedge Clock) begin
      if (capture) begin
         held <= fetchIn;
      end
      if (issue) begin
         decOut.op <= op;
         decOut.dest <= ra;
         decOut.opA <= rbData;
         decOut.opB <= isImm ? immExt : rcData;
         decOut.writeEn <= writes;
      end
   end

   // Every write-back lands on a register still marked busy
   aWriteBackBusy: assert property (@(posedge Clock) disable iff (!rstN)
      wbIn.writeEn && wbIn.idx != '0 |-> busy[wbIn.idx]);

endmodule

/* fetchStage.sv */
// Instruction fetch stage
`timescale 1ns/1ps
module fetchStage (
   input  logic          Clock,
   input  logic          rstN,
   output logic          memReq,
   output cpuPkg::addrT  memAddr,
   input  logic          memAck,
   input  cpuPkg::wordT  memData,
   output logic          fetchReq,
   input  logic          fetchAck,
   output cpuPkg::fetchT fetchOut
);
   import cpuPkg::*;

   typedef enum logic [2:0] {
      stIdle,
      stRequest,
      stRelease,
      stHandoff,
      stWaitAck
   } fetchStateT;

   fetchStateT state;
   addrT pc;

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         state <= stIdle;
         pc <= '0;
         memReq <= 1'b0;
         fetchReq <= 1'b0;
      end else begin
         case (state)
            stIdle: begin
               memReq <= 1'b1;
               state <= stRequest;
            end
            stRequest: begin
               if (memAck) begin
                  memReq <= 1'b0;
                  state <= stRelease;
               end
            end
            // Memory must drop its ack before decode sees the word
            stRelease: begin
               if (!memAck) begin
                  fetchReq <= 1'b1;
                  state <= stHandoff;
               end
            end
            stHandoff: begin
               if (fetchAck) begin
                  fetchReq <= 1'b0;
                  pc <= pc + 1'b1;
                  state <= stWaitAck;
               end
            end
            stWaitAck: begin
               if (!fetchAck) begin
                  state <= stIdle;
               end
            end
            default: state <= stIdle;
         endcase
      end
   end

   always_ff @(posedge Clock) begin
      if (state == stIdle) begin
         memAddr <= pc;
      end
      if (state == stRequest && memAck) begin
         fetchOut.instr <= memData;
         fetchOut.addr <= memAddr;
      end
   end

   aMemReqHeld: assert property (@(posedge Clock) disable iff (!rstN)
      memReq && !memAck |=> memReq);

   aMemAddrStable: assert property (@(posedge Clock) disable iff (!rstN)
      memReq && $past(memReq) |-> $stable(memAddr));

endmodule

/* regFile.sv */
// Register file
`timescale 1ns/1ps
module regFile (
   input  logic           Clock,
   input  logic           rstN,
   input  cpuPkg::regIdxT readIdxA,
   input  cpuPkg::regIdxT readIdxB,
   output cpuPkg::wordT   readDataA,
   output cpuPkg::wordT   readDataB,
   input  logic           writeEn,
   input  cpuPkg::regIdxT writeIdx,
   input  cpuPkg::wordT   writeData
);
   import cpuPkg::*;

   wordT regs [regCount];

   // Register zero reads as zero
   assign readDataA = (readIdxA == '0) ? '0 : regs[readIdxA];
   assign readDataB = (readIdxB == '0) ? '0 : regs[readIdxB];

   always_ff @(posedge Clock or negedge rstN) begin
      if (!rstN) begin
         for (int i = 0; i < regCount; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn && writeIdx != '0) begin
         regs[writeIdx] <= writeData;
      end
   end

endmodule

/* cpuPkg.sv */
// Processor core shared definitions
package cpuPkg;

   localparam int dataWidth = 32;
   localparam int regCount = 16;
   localparam int regIdxWidth = $clog2(regCount);
   localparam int immWidth = 19;

   typedef logic [dataWidth-1:0] wordT;
   typedef logic [dataWidth-1:0] addrT;
   typedef logic [regIdxWidth-1:0] regIdxT;
   typedef logic [immWidth-1:0] immT;

   typedef enum logic [4:0] {
      opNop  = 5'd0,
      opAdd  = 5'd1,
      opSub  = 5'd2,
      opAnd  = 5'd3,
      opOr   = 5'd4,
      opShl  = 5'd5,
      opAddi = 5'd6,
      opAndi = 5'd7,
      opOri  = 5'd8,
      opIn   = 5'd9,
      opOut  = 5'd10
   } opcodeT;

   // Instruction field positions
   localparam int opMsb = 31;
   localparam int opLsb = 27;
   localparam int raMsb = 26;
   localparam int raLsb = 23;
   localparam int rbMsb = 22;
   localparam int rbLsb = 19;
   localparam int rcMsb = 18;
   localparam int rcLsb = 15;
   localparam int immMsb = 18;
   localparam int immLsb = 0;

   // Fetch to decode
   typedef struct packed {
      wordT instr;
      addrT addr;
   } fetchT;

   // Decode to execute
   typedef struct packed {
      opcodeT op;
      regIdxT dest;
      wordT   opA;
      wordT   opB;
      logic   writeEn;
   } decodeT;

   // Execute to writeback
   typedef struct packed {
      opcodeT op;
      regIdxT dest;
      wordT   result;
      logic   writeEn;
   } execT;

   // Write pulse back to the register file
   typedef struct packed {
      logic   writeEn;
      regIdxT idx;
      wordT   data;
   } wbT;

endpackage
